/* Makefile */
# Verilator build and run for the MIPS control unit testbench

VERILATOR ?= verilator
TOP       ?= tbMipsControl
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
hdl/ctrlPkg.sv
hdl/opClassify.sv
hdl/stateSequencer.sv
hdl/branchResolve.sv
hdl/datapathControl.sv
hdl/mipsControlUnit.sv
verif/tbMipsControl.sv

/* hdl/branchResolve.sv */
`timescale 1ns/1ps

module branchResolve (
  input  logic                 clk,
  input  logic                 arstN,
  input  ctrlPkg::instrWord_u  instr,
  input  ctrlPkg::instrClass_t cls,
  input  logic                 retire,
  input  logic                 aluZero,
  input  logic                 lessThan,
  output logic                 branchPending
);

  logic taken;

  always_comb begin
    taken = 1'b0;
    if (cls.isJump) begin
      taken = 1'b1;
    end else if (cls.isBranch) begin
      case (instr.iFields.opcode)
        ctrlPkg::OP_BEQ:  taken = aluZero;
        ctrlPkg::OP_BNE:  taken = !aluZero;
        // aluZero holds the less-or-equal-zero compare here
        ctrlPkg::OP_BLEZ: taken = aluZero;
        ctrlPkg::OP_BGTZ: taken = !aluZero;
        ctrlPkg::OP_REGIMM: begin
          case (instr.iFields.rt)
            ctrlPkg::RI_BLTZ, ctrlPkg::RI_BLTZAL: taken = lessThan;
            ctrlPkg::RI_BGEZ, ctrlPkg::RI_BGEZAL: taken = !lessThan;
            default: taken = 1'b0;
          endcase
        end
        default: taken = 1'b0;
      endcase
    end
  end

  // Decision steers pcSrc in the following fetch
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      branchPending <= 1'b0;
    end else if (retire) begin
      branchPending <= taken;
    end
  end

endmodule

/* hdl/ctrlPkg.sv */
package ctrlPkg;

  // Instruction field widths
  localparam int instrWidth = 32;
  localparam int opWidth = 6;
  localparam int functWidth = 6;
  localparam int regWidth = 5;
  localparam int immWidth = instrWidth - opWidth - 2 * regWidth;

  // Byte lanes for each access width
  localparam logic [3:0] beWord = 4'b1111;
  localparam logic [3:0] beHalf = 4'b0011;
  localparam logic [3:0] beByte = 4'b0001;

  typedef enum logic [opWidth-1:0] {
    OP_RTYPE  = 6'b000000,
    OP_REGIMM = 6'b000001,
    OP_J      = 6'b000010,
    OP_JAL    = 6'b000011,
    OP_BEQ    = 6'b000100,
    OP_BNE    = 6'b000101,
    OP_BLEZ   = 6'b000110,
    OP_BGTZ   = 6'b000111,
    OP_ADDIU  = 6'b001001,
    OP_SLTI   = 6'b001010,
    OP_SLTIU  = 6'b001011,
    OP_ANDI   = 6'b001100,
    OP_ORI    = 6'b001101,
    OP_XORI   = 6'b001110,
    OP_LUI    = 6'b001111,
    OP_LB     = 6'b100000,
    OP_LH     = 6'b100001,
    OP_LW     = 6'b100011,
    OP_LBU    = 6'b100100,
    OP_LHU    = 6'b100101,
    OP_SW     = 6'b101011
  } opcode_t;

  // Functions not listed here fall back to a plain ALU add
  typedef enum logic [functWidth-1:0] {
    FN_JR   = 6'b001000,
    FN_JALR = 6'b001001,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_t;

  // Branch codes carried in the rt field of REGIMM
  typedef enum logic [regWidth-1:0] {
    RI_BLTZ   = 5'b00000,
    RI_BGEZ   = 5'b00001,
    RI_BLTZAL = 5'b10000,
    RI_BGEZAL = 5'b10001
  } regimm_t;

  typedef enum logic [2:0] {
    ST_HALTED  = 3'd0,
    ST_FETCH   = 3'd1,
    ST_MEMWAIT = 3'd2,
    ST_DECODE  = 3'd3,
    ST_EXEC1   = 3'd4,
    ST_EXEC2   = 3'd5,
    ST_EXEC3   = 3'd6
  } cpuState_t;

  typedef enum logic [4:0] {
    ALU_AND           = 5'b00000,
    ALU_OR            = 5'b00001,
    ALU_ADD           = 5'b00010,
    ALU_XOR           = 5'b00011,
    ALU_SLT           = 5'b00111,
    ALU_SLTU          = 5'b01000,
    ALU_COMPARE_EQ    = 5'b01010,
    ALU_PASS_B        = 5'b01011,
    ALU_BRANCH_TARGET = 5'b01101,
    ALU_PASS_A        = 5'b01110,
    ALU_COMPARE_LEZ   = 5'b10000,
    ALU_JUMP_TARGET   = 5'b10001,
    ALU_SHIFT_UPPER   = 5'b10100
  } aluOp_t;

  typedef struct packed {
    opcode_t opcode;
    logic [regWidth-1:0] rs;
    logic [regWidth-1:0] rt;
    logic [regWidth-1:0] rd;
    logic [regWidth-1:0] shamt;
    funct_t funct;
  } rFields_t;

  typedef struct packed {
    opcode_t opcode;
    logic [regWidth-1:0] rs;
    logic [regWidth-1:0] rt;
    logic [immWidth-1:0] imm16;
  } iFields_t;

  typedef union packed {
    rFields_t rFields;
    iFields_t iFields;
  } instrWord_u;

  typedef enum logic [1:0] {
    SRCB_REG         = 2'b00,
    SRCB_FOUR        = 2'b01,
    SRCB_IMM         = 2'b10,
    SRCB_IMM_SHIFTED = 2'b11
  } aluSrcB_t;

  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10
  } memWidth_t;

  typedef enum logic [1:0] {
    EXT_ZERO      = 2'b00,
    EXT_SIGN_BYTE = 2'b10,
    EXT_SIGN_HALF = 2'b11
  } extendMode_t;

  typedef struct packed {
    logic [1:0] execStates;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isJump;
    logic isLink;
    memWidth_t width;
    logic loadSigned;
  } instrClass_t;

  typedef struct packed {
    logic irWrite;
    logic pcWrite;
    logic iorD;
    logic aluSrcA;
    logic aluSel;
    logic regWrite;
    logic memToReg;
    logic regDst;
    logic pcSrc;
    logic extSel;
    logic memRead;
    logic memWrite;
    logic link;
    logic isJump;
    aluSrcB_t aluSrcB;
    aluOp_t aluOp;
    logic [3:0] byteEnable;
    extendMode_t extendMode;
  } ctrlWord_t;

endpackage

/* hdl/datapathControl.sv */
`timescale 1ns/1ps

module datapathControl (
  input  ctrlPkg::cpuState_t   state,
  input  ctrlPkg::instrWord_u  instr,
  input  ctrlPkg::instrClass_t cls,
  input  logic                 branchPending,
  output ctrlPkg::ctrlWord_t   ctrl
);

  // Per-instruction ALU step
  ctrlPkg::aluOp_t   opAlu;
  ctrlPkg::aluSrcB_t opSrcB;
  logic opSrcA;
  logic opExtSel;
  logic opRegWrite;
  logic opRegDst;
  logic isRtype;
  logic [3:0] memBe;
  ctrlPkg::extendMode_t memExt;

  assign isRtype = (instr.iFields.opcode == ctrlPkg::OP_RTYPE);

  always_comb begin
    opAlu = ctrlPkg::ALU_ADD;
    opSrcB = ctrlPkg::SRCB_IMM;
    opSrcA = 1'b1;
    opExtSel = 1'b0;
    opRegWrite = 1'b0;
    opRegDst = 1'b0;
    case (instr.iFields.opcode)
      ctrlPkg::OP_RTYPE: begin
        opSrcB = ctrlPkg::SRCB_REG;
        opRegWrite = 1'b1;
        opRegDst = 1'b1;
        case (instr.rFields.funct)
          ctrlPkg::FN_JR, ctrlPkg::FN_JALR: begin
            opAlu = ctrlPkg::ALU_PASS_A;
            opRegWrite = 1'b0;
          end
          ctrlPkg::FN_AND:  opAlu = ctrlPkg::ALU_AND;
          ctrlPkg::FN_OR:   opAlu = ctrlPkg::ALU_OR;
          ctrlPkg::FN_XOR:  opAlu = ctrlPkg::ALU_XOR;
          ctrlPkg::FN_SLT:  opAlu = ctrlPkg::ALU_SLT;
          ctrlPkg::FN_SLTU: opAlu = ctrlPkg::ALU_SLTU;
          default:          opAlu = ctrlPkg::ALU_ADD;
        endcase
      end
      ctrlPkg::OP_REGIMM: opAlu = ctrlPkg::ALU_PASS_A;
      ctrlPkg::OP_J, ctrlPkg::OP_JAL: begin
        opAlu = ctrlPkg::ALU_JUMP_TARGET;
        opSrcA = 1'b0;
        opSrcB = ctrlPkg::SRCB_IMM_SHIFTED;
        opExtSel = 1'b1;
      end
      ctrlPkg::OP_BEQ, ctrlPkg::OP_BNE: begin
        opAlu = ctrlPkg::ALU_COMPARE_EQ;
        opSrcB = ctrlPkg::SRCB_REG;
      end
      ctrlPkg::OP_BLEZ, ctrlPkg::OP_BGTZ: opAlu = ctrlPkg::ALU_COMPARE_LEZ;
      ctrlPkg::OP_ADDIU: opRegWrite = 1'b1;
      ctrlPkg::OP_SLTI: begin
        opAlu = ctrlPkg::ALU_SLT;
        opRegWrite = 1'b1;
      end
      ctrlPkg::OP_SLTIU: begin
        opAlu = ctrlPkg::ALU_SLTU;
        opRegWrite = 1'b1;
      end
      // Logical immediates are zero extended
      ctrlPkg::OP_ANDI: begin
        opAlu = ctrlPkg::ALU_AND;
        opExtSel = 1'b1;
        opRegWrite = 1'b1;
      end
      ctrlPkg::OP_ORI: begin
        opAlu = ctrlPkg::ALU_OR;
        opExtSel = 1'b1;
        opRegWrite = 1'b1;
      end
      ctrlPkg::OP_XORI: begin
        opAlu = ctrlPkg::ALU_XOR;
        opExtSel = 1'b1;
        opRegWrite = 1'b1;
      end
      ctrlPkg::OP_LUI: begin
        opAlu = ctrlPkg::ALU_SHIFT_UPPER;
        opRegWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // Byte lanes and extension for the data access
  always_comb begin
    memBe = ctrlPkg::beWord;
    memExt = ctrlPkg::EXT_ZERO;
    case (cls.width)
      ctrlPkg::MEM_HALF: begin
        memBe = ctrlPkg::beHalf;
        if (cls.loadSigned) memExt = ctrlPkg::EXT_SIGN_HALF;
      end
      ctrlPkg::MEM_BYTE: begin
        memBe = ctrlPkg::beByte;
        if (cls.loadSigned) memExt = ctrlPkg::EXT_SIGN_BYTE;
      end
      default: ;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.byteEnable = ctrlPkg::beWord;
    ctrl.aluSrcB = ctrlPkg::SRCB_REG;
    ctrl.aluOp = ctrlPkg::ALU_AND;
    ctrl.extendMode = ctrlPkg::EXT_ZERO;
    case (state)
      ctrlPkg::ST_FETCH: begin
        ctrl.memRead = 1'b1;
        ctrl.pcWrite = 1'b1;
        ctrl.pcSrc = branchPending;
        ctrl.aluSrcB = ctrlPkg::SRCB_FOUR;
        ctrl.aluOp = ctrlPkg::ALU_ADD;
      end
      ctrlPkg::ST_MEMWAIT: ctrl.memRead = 1'b1;
      // Speculative branch target while the instruction is latched
      ctrlPkg::ST_DECODE: begin
        ctrl.irWrite = 1'b1;
        ctrl.aluSrcB = ctrlPkg::SRCB_IMM_SHIFTED;
        ctrl.aluOp = ctrlPkg::ALU_BRANCH_TARGET;
      end
      ctrlPkg::ST_EXEC1: begin
        if (cls.isLink && !cls.isLoad && !cls.isStore) begin
          // Return address PC plus four into r31 or rd
          ctrl.aluSrcB = ctrlPkg::SRCB_FOUR;
          ctrl.aluOp = ctrlPkg::ALU_ADD;
          ctrl.regWrite = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.regDst = isRtype;
          ctrl.link = !isRtype;
        end else begin
          ctrl.aluSrcA = opSrcA;
          ctrl.aluSrcB = opSrcB;
          ctrl.aluOp = opAlu;
          ctrl.extSel = opExtSel;
          ctrl.isJump = cls.isJump;
          ctrl.aluSel = cls.isBranch;
        end
      end
      ctrlPkg::ST_EXEC2: begin
        if (cls.isLoad || cls.isStore) begin
          ctrl.iorD = 1'b1;
          ctrl.aluSel = 1'b1;
          ctrl.memRead = cls.isLoad;
          ctrl.memWrite = cls.isStore;
          ctrl.byteEnable = memBe;
          ctrl.extendMode = memExt;
        end else if (cls.isLink && cls.isJump) begin
          ctrl.aluSrcA = opSrcA;
          ctrl.aluSrcB = opSrcB;
          ctrl.aluOp = opAlu;
          ctrl.extSel = opExtSel;
          ctrl.isJump = 1'b1;
        end else if (cls.isLink) begin
          // Link overwrote the target, so rebuild it for the branch
          ctrl.aluSrcB = ctrlPkg::SRCB_IMM_SHIFTED;
          ctrl.aluOp = ctrlPkg::ALU_BRANCH_TARGET;
        end else begin
          ctrl.aluSel = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.regDst = opRegDst;
          ctrl.regWrite = opRegWrite;
        end
      end
      ctrlPkg::ST_EXEC3: begin
        ctrl.regWrite = 1'b1;
        ctrl.byteEnable = memBe;
        ctrl.extendMode = memExt;
      end
      default: ;
    endcase
  end

endmodule

/* hdl/mipsControlUnit.sv */
`timescale 1ns/1ps

module mipsControlUnit (
  input  logic                clk,
  input  logic                arstN,
  input  logic                start,
  input  logic                pcIsZero,
  input  logic                waitRequest,
  input  logic                aluBusy,
  input  logic                aluZero,
  input  logic                lessThan,
  input  ctrlPkg::instrWord_u instr,
  output ctrlPkg::ctrlWord_t  ctrl,
  output ctrlPkg::cpuState_t  state,
  output logic                active
);

  ctrlPkg::instrClass_t cls;
  logic retire;
  logic branchPending;

  opClassify opClassify_inst (
    .instr (instr),
    .cls   (cls)
  );

  stateSequencer stateSequencer_inst (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .aluBusy     (aluBusy),
    .cls         (cls),
    .state       (state),
    .retire      (retire)
  );

  branchResolve branchResolve_inst (
    .clk           (clk),
    .arstN         (arstN),
    .instr         (instr),
    .cls           (cls),
    .retire        (retire),
    .aluZero       (aluZero),
    .lessThan      (lessThan),
    .branchPending (branchPending)
  );

  datapathControl datapathControl_inst (
    .state         (state),
    .instr         (instr),
    .cls           (cls),
    .branchPending (branchPending),
    .ctrl          (ctrl)
  );

  assign active = (state != ctrlPkg::ST_HALTED);

endmodule

/* hdl/opClassify.sv */
`timescale 1ns/1ps

module opClassify (
  input  ctrlPkg::instrWord_u  instr,
  output ctrlPkg::instrClass_t cls
);

  always_comb begin
    // Unknown opcodes run as two-state ALU ops
    cls = '0;
    cls.execStates = 2'd2;
    cls.width = ctrlPkg::MEM_WORD;
    case (instr.iFields.opcode)
      ctrlPkg::OP_RTYPE: begin
        if (instr.rFields.funct == ctrlPkg::FN_JR) begin
          cls.execStates = 2'd1;
          cls.isJump = 1'b1;
        end else if (instr.rFields.funct == ctrlPkg::FN_JALR) begin
          cls.isJump = 1'b1;
          cls.isLink = 1'b1;
        end
      end
      ctrlPkg::OP_REGIMM: begin
        case (instr.iFields.rt)
          ctrlPkg::RI_BLTZ, ctrlPkg::RI_BGEZ: begin
            cls.execStates = 2'd1;
            cls.isBranch = 1'b1;
          end
          ctrlPkg::RI_BLTZAL, ctrlPkg::RI_BGEZAL: begin
            cls.isBranch = 1'b1;
            cls.isLink = 1'b1;
          end
          default: ;
        endcase
      end
      ctrlPkg::OP_J: begin
        cls.execStates = 2'd1;
        cls.isJump = 1'b1;
      end
      ctrlPkg::OP_JAL: begin
        cls.isJump = 1'b1;
        cls.isLink = 1'b1;
      end
      ctrlPkg::OP_BEQ, ctrlPkg::OP_BNE, ctrlPkg::OP_BLEZ, ctrlPkg::OP_BGTZ: begin
        cls.execStates = 2'd1;
        cls.isBranch = 1'b1;
      end
      ctrlPkg::OP_LB, ctrlPkg::OP_LH, ctrlPkg::OP_LW, ctrlPkg::OP_LBU,
      ctrlPkg::OP_LHU: begin
        cls.execStates = 2'd3;
        cls.isLoad = 1'b1;
        cls.loadSigned = (instr.iFields.opcode == ctrlPkg::OP_LB) ||
                         (instr.iFields.opcode == ctrlPkg::OP_LH);
        if (instr.iFields.opcode == ctrlPkg::OP_LB ||
            instr.iFields.opcode == ctrlPkg::OP_LBU) begin
          cls.width = ctrlPkg::MEM_BYTE;
        end else if (instr.iFields.opcode == ctrlPkg::OP_LH ||
                     instr.iFields.opcode == ctrlPkg::OP_LHU) begin
          cls.width = ctrlPkg::MEM_HALF;
        end
      end
      ctrlPkg::OP_SW: cls.isStore = 1'b1;
      default: ;
    endcase
  end

endmodule

/* hdl/stateSequencer.sv */
`timescale 1ns/1ps

module stateSequencer (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 start,
  input  logic                 pcIsZero,
  input  logic                 waitRequest,
  input  logic                 aluBusy,
  input  ctrlPkg::instrClass_t cls,
  output ctrlPkg::cpuState_t   state,
  output logic                 retire
);

  ctrlPkg::cpuState_t nextState;
  logic inExec;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ctrlPkg::ST_HALTED;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ctrlPkg::ST_HALTED: begin
        if (start) begin
          nextState = ctrlPkg::ST_FETCH;
        end
      end
      // Instruction fetch waits on memory
      ctrlPkg::ST_FETCH, ctrlPkg::ST_MEMWAIT: begin
        if (waitRequest) begin
          nextState = ctrlPkg::ST_MEMWAIT;
        end else begin
          nextState = ctrlPkg::ST_DECODE;
        end
      end
      ctrlPkg::ST_DECODE: nextState = ctrlPkg::ST_EXEC1;
      ctrlPkg::ST_EXEC1: begin
        if (aluBusy) begin
          nextState = ctrlPkg::ST_EXEC1;
        end else if (cls.execStates > 2'd1) begin
          nextState = ctrlPkg::ST_EXEC2;
        end else begin
          nextState = ctrlPkg::ST_FETCH;
        end
      end
      // Data access waits on memory
      ctrlPkg::ST_EXEC2: begin
        if (waitRequest) begin
          nextState = ctrlPkg::ST_EXEC2;
        end else if (cls.execStates == 2'd3) begin
          nextState = ctrlPkg::ST_EXEC3;
        end else begin
          nextState = ctrlPkg::ST_FETCH;
        end
      end
      ctrlPkg::ST_EXEC3: nextState = ctrlPkg::ST_FETCH;
      default: nextState = ctrlPkg::ST_HALTED;
    endcase
    // PC of zero stops the machine from any running state
    if (pcIsZero && state != ctrlPkg::ST_HALTED) begin
      nextState = ctrlPkg::ST_HALTED;
    end
  end

  assign inExec = (state == ctrlPkg::ST_EXEC1) ||
                  (state == ctrlPkg::ST_EXEC2) ||
                  (state == ctrlPkg::ST_EXEC3);

  // Last execute state completing toward the next fetch
  assign retire = inExec && (nextState == ctrlPkg::ST_FETCH);

endmodule

/* verif/tbMipsControl.sv */
`timescale 1ns/1ps

module tbMipsControl;

  localparam int halfPeriod = 20;
  localparam int maxWait = 7;
  localparam int numRandom = 40;
  localparam int numStall = 30;
  localparam int numMemory = 20;
  localparam int numBranch = 30;
  localparam int numHalt = 10;
  // Longest instruction, waits in fetch, EXEC1 and EXEC2, and the halt restart
  localparam int worstCycles = 5 + 3 * maxWait + 6;
  localparam int totalInstr = numRandom + numStall + numMemory + numBranch + numHalt;
  localparam longint watchdogNs = 2 * (totalInstr + 8) * worstCycles * 2 * halfPeriod;

  localparam logic [5:0] allOps [21] = '{
    ctrlPkg::OP_RTYPE, ctrlPkg::OP_REGIMM, ctrlPkg::OP_J, ctrlPkg::OP_JAL, ctrlPkg::OP_BEQ,
    ctrlPkg::OP_BNE, ctrlPkg::OP_BLEZ, ctrlPkg::OP_BGTZ, ctrlPkg::OP_ADDIU, ctrlPkg::OP_SLTI,
    ctrlPkg::OP_SLTIU, ctrlPkg::OP_ANDI, ctrlPkg::OP_ORI, ctrlPkg::OP_XORI, ctrlPkg::OP_LUI,
    ctrlPkg::OP_LB, ctrlPkg::OP_LH, ctrlPkg::OP_LW, ctrlPkg::OP_LBU, ctrlPkg::OP_LHU,
    ctrlPkg::OP_SW};
  localparam logic [5:0] memOps [6] = '{ctrlPkg::OP_LB, ctrlPkg::OP_LH, ctrlPkg::OP_LW,
    ctrlPkg::OP_LBU, ctrlPkg::OP_LHU, ctrlPkg::OP_SW};
  // R-type stays in the mix so non-branch flow is covered
  localparam logic [5:0] flowOps [8] = '{ctrlPkg::OP_REGIMM, ctrlPkg::OP_J, ctrlPkg::OP_JAL,
    ctrlPkg::OP_BEQ, ctrlPkg::OP_BNE, ctrlPkg::OP_BLEZ, ctrlPkg::OP_BGTZ, ctrlPkg::OP_RTYPE};
  localparam logic [5:0] functs [8] = '{ctrlPkg::FN_JR, ctrlPkg::FN_JALR, ctrlPkg::FN_ADDU,
    ctrlPkg::FN_AND, ctrlPkg::FN_OR, ctrlPkg::FN_XOR, ctrlPkg::FN_SLT, ctrlPkg::FN_SLTU};
  localparam logic [4:0] rimmCodes [4] = '{ctrlPkg::RI_BLTZ, ctrlPkg::RI_BGEZ,
    ctrlPkg::RI_BLTZAL, ctrlPkg::RI_BGEZAL};

  logic clk;
  logic arstN;
  logic start;
  logic pcIsZero;
  logic waitRequest;
  logic aluBusy;
  logic aluZero;
  logic lessThan;
  ctrlPkg::instrWord_u instr;
  ctrlPkg::ctrlWord_t ctrl;
  ctrlPkg::cpuState_t state;
  logic active;

  ctrlPkg::ctrlWord_t haltWord;
  logic [$bits(ctrlPkg::ctrlWord_t)-1:0] ctrlBits;
  logic [31:0] lfsr;
  string testName;
  int errors;
  int testErrStart;
  int testsRun;
  int testsFailed;
  logic expPc;
  logic expLoad;
  logic expStore;
  logic expAluWrite;
  logic [3:0] expBe;
  logic [1:0] expExt;

  mipsControlUnit mipsControlUnit_inst (.*);

  always #halfPeriod clk = ~clk;

  assign ctrlBits = ctrl;

  task automatic reportError(input string check, input logic [63:0] expVal,
                             input logic [63:0] actVal);
    $display("error %s %s: expected %0h, actual %0h", testName, check, expVal, actVal);
    errors++;
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic isLoadOp(input logic [5:0] op);
    return op == ctrlPkg::OP_LB || op == ctrlPkg::OP_LH || op == ctrlPkg::OP_LW ||
           op == ctrlPkg::OP_LBU || op == ctrlPkg::OP_LHU;
  endfunction

  function automatic int execStatesOf(input logic [31:0] w);
    if (isLoadOp(w[31:26])) return 3;
    case (w[31:26])
      ctrlPkg::OP_J, ctrlPkg::OP_BEQ, ctrlPkg::OP_BNE, ctrlPkg::OP_BLEZ,
      ctrlPkg::OP_BGTZ: return 1;
      ctrlPkg::OP_RTYPE: return (w[5:0] == ctrlPkg::FN_JR) ? 1 : 2;
      ctrlPkg::OP_REGIMM: return (w[20:16] == ctrlPkg::RI_BLTZ ||
                                  w[20:16] == ctrlPkg::RI_BGEZ) ? 1 : 2;
      default: return 2;
    endcase
  endfunction

  function automatic logic takenOf(input logic [31:0] w, input logic z, input logic lt);
    case (w[31:26])
      ctrlPkg::OP_J, ctrlPkg::OP_JAL: return 1'b1;
      ctrlPkg::OP_RTYPE: return w[5:0] == ctrlPkg::FN_JR || w[5:0] == ctrlPkg::FN_JALR;
      ctrlPkg::OP_BEQ, ctrlPkg::OP_BLEZ: return z;
      ctrlPkg::OP_BNE, ctrlPkg::OP_BGTZ: return !z;
      ctrlPkg::OP_REGIMM: begin
        if (w[20:16] == ctrlPkg::RI_BLTZ || w[20:16] == ctrlPkg::RI_BLTZAL) return lt;
        if (w[20:16] == ctrlPkg::RI_BGEZ || w[20:16] == ctrlPkg::RI_BGEZAL) return !lt;
        return 1'b0;
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic aluWriteOf(input logic [31:0] w);
    if (w[31:26] == ctrlPkg::OP_RTYPE) begin
      return w[5:0] != ctrlPkg::FN_JR && w[5:0] != ctrlPkg::FN_JALR;
    end
    return w[31:26] inside {ctrlPkg::OP_ADDIU, ctrlPkg::OP_SLTI, ctrlPkg::OP_SLTIU,
      ctrlPkg::OP_ANDI, ctrlPkg::OP_ORI, ctrlPkg::OP_XORI, ctrlPkg::OP_LUI};
  endfunction

  always_comb begin
    expLoad = isLoadOp(instr[31:26]);
    expStore = instr[31:26] == ctrlPkg::OP_SW;
    expAluWrite = aluWriteOf(instr);
    expBe = 4'b1111;
    expExt = ctrlPkg::EXT_ZERO;
    if (instr[31:26] == ctrlPkg::OP_LH || instr[31:26] == ctrlPkg::OP_LHU) expBe = 4'b0011;
    if (instr[31:26] == ctrlPkg::OP_LB || instr[31:26] == ctrlPkg::OP_LBU) expBe = 4'b0001;
    if (instr[31:26] == ctrlPkg::OP_LH) expExt = ctrlPkg::EXT_SIGN_HALF;
    if (instr[31:26] == ctrlPkg::OP_LB) expExt = ctrlPkg::EXT_SIGN_BYTE;
  end

  haltedQuiet: assert property (@(posedge clk) state == ctrlPkg::ST_HALTED |->
      !active && ctrl == haltWord)
    else reportError("haltedCtrl", 64'(haltWord), 64'($sampled(ctrlBits)));
  runningActive: assert property (@(posedge clk) disable iff (!arstN)
      state != ctrlPkg::ST_HALTED |-> active)
    else reportError("activeRun", 64'(1), 64'($sampled(active)));
  startFetch: assert property (@(posedge clk) disable iff (!arstN)
      state == ctrlPkg::ST_HALTED && start && !pcIsZero |=>
      state == ctrlPkg::ST_FETCH && ctrl.memRead && ctrl.pcWrite)
    else reportError("startFetch", 64'(ctrlPkg::ST_FETCH), 64'($sampled(state)));
  // Back-pressure must not disturb the control word
  holdStable: assert property (@(posedge clk) disable iff (!arstN)
      $stable(state) && state != ctrlPkg::ST_HALTED |-> $stable(ctrlBits))
    else reportError("holdCtrl", 64'($past(ctrlBits)), 64'($sampled(ctrlBits)));
  writeOnlyExec2: assert property (@(posedge clk) disable iff (!arstN)
      ctrl.memWrite |-> state == ctrlPkg::ST_EXEC2)
    else reportError("memWriteState", 64'(ctrlPkg::ST_EXEC2), 64'($sampled(state)));
  loadAccess: assert property (@(posedge clk) disable iff (!arstN)
      state == ctrlPkg::ST_EXEC2 && expLoad |-> ctrl.memRead && ctrl.iorD &&
      ctrl.byteEnable == expBe && ctrl.extendMode == expExt)
    else reportError("loadAccess", 64'({2'b11, expBe, expExt}),
                     64'($sampled({ctrl.memRead, ctrl.iorD, ctrl.byteEnable, ctrl.extendMode})));
  storeAccess: assert property (@(posedge clk) disable iff (!arstN)
      state == ctrlPkg::ST_EXEC2 && expStore |-> ctrl.memWrite && ctrl.byteEnable == 4'b1111)
    else reportError("storeAccess", 64'(5'h1f),
                     64'($sampled({ctrl.memWrite, ctrl.byteEnable})));
  lastRegWrite: assert property (@(posedge clk) disable iff (!arstN)
      (state == ctrlPkg::ST_EXEC3 && expLoad) || (state == ctrlPkg::ST_EXEC2 && expAluWrite)
      |-> ctrl.regWrite)
    else reportError("regWrite", 64'(1), 64'($sampled(ctrl.regWrite)));
  fetchPcSrc: assert property (@(posedge clk) disable iff (!arstN)
      state == ctrlPkg::ST_FETCH |-> ctrl.pcSrc == expPc)
    else reportError("pcSrc", 64'(expPc), 64'($sampled(ctrl.pcSrc)));
  haltOnZero: assert property (@(posedge clk) disable iff (!arstN)
      pcIsZero && state != ctrlPkg::ST_HALTED |=> state == ctrlPkg::ST_HALTED && !active)
    else reportError("haltState", 64'(ctrlPkg::ST_HALTED), 64'($sampled(state)));

  function automatic logic [31:0] pickInstr(input int kind);
    logic [31:0] w;
    int idx;
    w = randBits(26);
    case (kind)
      1: idx = int'(randBits(3) % 6);
      2: idx = int'(randBits(3));
      default: idx = int'(randBits(5) % 21);
    endcase
    w[31:26] = (kind == 1) ? memOps[idx] : (kind == 2) ? flowOps[idx] : allOps[idx];
    idx = int'(randBits(3));
    if (w[31:26] == ctrlPkg::OP_RTYPE) w[5:0] = functs[idx];
    if (w[31:26] == ctrlPkg::OP_REGIMM) w[20:16] = rimmCodes[idx % 4];
    return w;
  endfunction

  // Starts on the edge that enters FETCH and returns on the edge that leaves the instruction
  task automatic runInstr(input logic [31:0] w, input int wFetch, input int busy,
                          input int wMem, input int haltPick);
    int es;
    int len;
    int haltAt;
    int fetchSeen;
    logic z;
    logic lt;
    es = execStatesOf(w);
    len = 2 + es + wFetch + busy + ((es > 1) ? wMem : 0);
    haltAt = (haltPick < 0) ? -1 : haltPick % len;
    z = randBits(1) != 0;
    lt = randBits(1) != 0;
    fetchSeen = 0;
    for (int c = 0; c < len; c++) begin
      if (c == 0) begin
        instr <= w;
        aluZero <= z;
        lessThan <= lt;
      end
      waitRequest <= (c < wFetch) || (es > 1 && c >= wFetch + 3 + busy &&
                                       c < wFetch + 3 + busy + wMem);
      aluBusy <= (c >= wFetch + 2) && (c < wFetch + 2 + busy);
      pcIsZero <= (c == haltAt);
      @(negedge clk);
      if (c == 0) begin
        assert (state == ctrlPkg::ST_FETCH)
          else reportError("fetchEntry", 64'(ctrlPkg::ST_FETCH), 64'(state));
      end else if (state == ctrlPkg::ST_FETCH) begin
        fetchSeen++;
      end
      @(posedge clk);
      if (c == haltAt) break;
    end
    if (haltAt < 0) begin
      assert (fetchSeen == 0) else reportError("earlyFetch", 64'(0), 64'(fetchSeen));
      expPc = takenOf(w, z, lt);
    end else begin
      pcIsZero <= 1'b0;
      waitRequest <= 1'b0;
      aluBusy <= 1'b0;
      repeat (3) begin
        @(negedge clk);
        assert (state == ctrlPkg::ST_HALTED && !active)
          else $display("error %s: machine left HALTED without start", testName);
        if (state != ctrlPkg::ST_HALTED || active) errors++;
        @(posedge clk);
      end
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
  endtask

  task automatic runTest(input string name, input int count, input int kind,
                         input logic stalls, input logic halts);
    int wf;
    int ab;
    int wm;
    testName = name;
    testErrStart = errors;
    for (int i = 0; i < count; i++) begin
      wf = stalls ? int'(randBits(3)) : 0;
      ab = stalls ? int'(randBits(3)) : 0;
      wm = stalls ? int'(randBits(3)) : 0;
      runInstr(pickInstr(kind), wf, ab, wm, halts ? int'(randBits(5)) : -1);
    end
    testsRun++;
    if (errors == testErrStart) begin
      $display("test %s: pass, %0d instructions", name, count);
    end else begin
      testsFailed++;
      $display("test %s: %0d errors", name, errors - testErrStart);
    end
  endtask

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    start = 1'b0;
    pcIsZero = 1'b0;
    waitRequest = 1'b0;
    aluBusy = 1'b0;
    aluZero = 1'b0;
    lessThan = 1'b0;
    instr = '0;
    lfsr = 32'hf75b_d92e;
    haltWord = '0;
    haltWord.byteEnable = 4'b1111;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    expPc = 1'b0;
    testName = "reset";
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    repeat (2) @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    testsRun++;
    $display("test reset: %0d errors", errors);
    if (errors != 0) testsFailed++;
    runTest("length", numRandom, 0, 1'b0, 1'b0);
    runTest("stalls", numStall, 0, 1'b1, 1'b0);
    runTest("memory", numMemory, 1, 1'b1, 1'b0);
    runTest("branch", numBranch, 2, 1'b0, 1'b0);
    runTest("halt", numHalt, 0, 1'b1, 1'b1);
    @(negedge clk);
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("timeout: the tests did not finish within %0d ns", watchdogNs);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
